// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it
# Exit status is zero only when the testbench prints its pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
  --top-module ex_stage_tb -f sim.f -o ex_stage_sim &&
./obj_dir/ex_stage_sim | tee /dev/stderr | grep -x "Test passed" > /dev/null &&
echo "Simulation run complete" ||
{
  echo "Simulation did not pass" >&2
  exit 1
}

// ==== sim.f ====
source/ex_cfg_pkg.sv
source/ex_types_pkg.sv
source/ex_alu.sv
source/ex_issue_ctrl.sv
source/ex_mul_stage.sv
source/ex_wb_arbiter.sv
source/ex_stage.sv
verification/ex_stage_assert.sv
verification/ex_stage_tb.sv

// ==== source/ex_alu.sv ====
// Purely combinational, shifts use only the low SHAMT_W bits of op_b and compares give one flag
`timescale 1ns/10ps

module ex_alu
  import ex_cfg_pkg::*;
  import ex_types_pkg::*;
(
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_o
);

  logic [SHAMT_W-1:0] shamt;
  logic               is_equal;
  logic               less_signed;
  logic               less_unsigned;
  logic               cmp;

  ////////////////////////////////////////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////////////////////////////////////////

  assign shamt         = op_b_i[SHAMT_W-1:0];
  assign is_equal      = (op_a_i == op_b_i);
  assign less_signed   = ($signed(op_a_i) < $signed(op_b_i));
  assign less_unsigned = (op_a_i < op_b_i);

  // One flag for every compare opcode
  // SLT and SLTU share the less-than paths with the branches
  always_comb begin
    case (op_i)
      ALU_EQ:            cmp = is_equal;
      ALU_NE:            cmp = ~is_equal;
      ALU_LT, ALU_SLT:   cmp = less_signed;
      ALU_GE:            cmp = ~less_signed;
      ALU_LTU, ALU_SLTU: cmp = less_unsigned;
      ALU_GEU:           cmp = ~less_unsigned;
      default:           cmp = 1'b0;
    endcase
  end

  // Branch decision goes out unchanged
  assign cmp_o = cmp;

  ////////////////////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op_i)
      ALU_ADD: result_o = op_a_i + op_b_i;
      ALU_SUB: result_o = op_a_i - op_b_i;
      ALU_AND: result_o = op_a_i & op_b_i;
      ALU_OR:  result_o = op_a_i | op_b_i;
      ALU_XOR: result_o = op_a_i ^ op_b_i;
      // Shifts
      ALU_SLL: result_o = op_a_i << shamt;
      ALU_SRL: result_o = op_a_i >> shamt;
      ALU_SRA: result_o = $unsigned($signed(op_a_i) >>> shamt);
      // Set-less-than and the branch compares
      // Flag lands in bit 0, upper bits zero
      default: result_o = {{(XLEN-1){1'b0}}, cmp};
    endcase
  end

endmodule

// ==== source/ex_cfg_pkg.sv ====
// Sizes are fixed here, and XLEN must be a whole multiple of MUL_DIGIT_W for the multiplier
package ex_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////

  // Machine word
  localparam int unsigned XLEN = 32;
  // Shift amount taken from the low bits of operand b
  localparam int unsigned SHAMT_W = $clog2(XLEN);

  // Register file address, x0 reads as zero and is never written
  localparam int unsigned REG_ADDR_W = 5;

  ////////////////////////////////////////////////////////////////////////////
  // Multiplier pipeline
  ////////////////////////////////////////////////////////////////////////////

  // Bits of operand b consumed by one stage
  localparam int unsigned MUL_DIGIT_W = 8;
  // One stage per digit, this is also the multiply latency in cycles
  localparam int unsigned MUL_STAGES = XLEN / MUL_DIGIT_W;

endpackage

// ==== source/ex_issue_ctrl.sv ====
// Decode holds issue_i until accepted, and hazards against multiplies in flight are decode's job
`timescale 1ns/10ps

module ex_issue_ctrl
  import ex_cfg_pkg::*;
  import ex_types_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  ex_issue_t       issue_i,
  input  logic [XLEN-1:0] alu_result_i,
  input  logic            alu_cmp_i,
  input  logic            wb_ready_i,
  input  logic            contention_i,
  output logic            ex_ready_o,
  output logic            ex_valid_o,
  output mul_flight_t     mul_o,
  output rf_write_t       alu_wr_o,
  output rf_write_t       load_wr_o,
  output logic            branch_decision_o,
  output logic [XLEN-1:0] jump_target_o
);

  logic                  is_alu;
  logic                  is_branch;
  logic                  is_mul;
  logic                  is_load;
  logic                  rd_write;
  logic                  accept;
  logic                  load_we_q;
  logic [REG_ADDR_W-1:0] load_waddr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Decode of the incoming instruction
  ////////////////////////////////////////////////////////////////////////////

  assign is_alu    = issue_i.valid & (issue_i.unit == UNIT_ALU);
  assign is_branch = issue_i.valid & (issue_i.unit == UNIT_BRANCH);
  assign is_mul    = issue_i.valid & (issue_i.unit == UNIT_MUL);
  assign is_load   = issue_i.valid & (issue_i.unit == UNIT_LOAD);
  // x0 writes dropped here
  assign rd_write  = issue_i.we & (issue_i.waddr != '0);

  // Branches write nothing, so they pass back-pressure and contention
  assign ex_ready_o = (wb_ready_i & ~contention_i) | is_branch;
  assign ex_valid_o = issue_i.valid & ex_ready_o;
  assign accept     = ex_valid_o;

  // Branch outcome in the accept cycle
  assign branch_decision_o = is_branch & alu_cmp_i;
  assign jump_target_o     = issue_i.op_c;

  ////////////////////////////////////////////////////////////////////////////
  // ALU write and multiply launch
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Not gated by contention, the arbiter gives the port to the multiplier then
    alu_wr_o.we    = is_alu & rd_write & wb_ready_i;
    alu_wr_o.waddr = issue_i.waddr;
    alu_wr_o.wdata = alu_result_i;

    // Stage 0 input, launched only on acceptance
    mul_o.valid = accept & is_mul & rd_write;
    mul_o.waddr = issue_i.waddr;
    mul_o.op_a  = issue_i.op_a;
    mul_o.op_b  = issue_i.op_b;
    // MAC seeds the sum with op_c
    mul_o.acc   = (issue_i.mul_op == MUL_MAC) ? issue_i.op_c : '0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB load register
  ////////////////////////////////////////////////////////////////////////////

  // Flushed when WB is free and nothing new arrives
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_we_q <= 1'b0;
    end else if (accept) begin
      load_we_q <= is_load & rd_write;
    end else if (wb_ready_i) begin
      load_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && is_load && rd_write) begin
      load_waddr_q <= issue_i.waddr;
    end
  end

  // Data comes from the load unit in the arbiter
  always_comb begin
    load_wr_o.we    = load_we_q;
    load_wr_o.waddr = load_waddr_q;
    load_wr_o.wdata = '0;
  end

endmodule

// ==== source/ex_mul_stage.sv ====
// Keeps only the low XLEN bits of the product, never stalls, STAGE_IDX must match chain position
`timescale 1ns/10ps

module ex_mul_stage
  import ex_cfg_pkg::*;
  import ex_types_pkg::*;
#(
  parameter int unsigned STAGE_IDX = 0
) (
  input  logic        clk,
  input  logic        rst_n,
  input  mul_flight_t flight_i,
  output mul_flight_t flight_o
);

  logic [MUL_DIGIT_W-1:0] digit;
  logic [XLEN-1:0]        partial;
  logic                   valid_q;
  logic [REG_ADDR_W-1:0]  waddr_q;
  logic [XLEN-1:0]        op_a_q;
  logic [XLEN-1:0]        op_b_q;
  logic [XLEN-1:0]        acc_q;

  // Lowest remaining digit times op_a, moved up to this stage's weight
  assign digit   = flight_i.op_b[MUL_DIGIT_W-1:0];
  assign partial = (flight_i.op_a * XLEN'(digit)) << (STAGE_IDX * MUL_DIGIT_W);

  // Valid bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= flight_i.valid;
    end
  end

  // Payload moves only with a product
  always_ff @(posedge clk) begin
    if (flight_i.valid) begin
      waddr_q <= flight_i.waddr;
      op_a_q  <= flight_i.op_a;
      // Next stage sees the next digit at the bottom
      op_b_q  <= flight_i.op_b >> MUL_DIGIT_W;
      acc_q   <= flight_i.acc + partial;
    end
  end

  always_comb begin
    flight_o.valid = valid_q;
    flight_o.waddr = waddr_q;
    flight_o.op_a  = op_a_q;
    flight_o.op_b  = op_b_q;
    flight_o.acc   = acc_q;
  end

endmodule

// ==== source/ex_stage.sv ====
// Single-issue execute stage, multiplies return after MUL_STAGES cycles with no hazard checks
`timescale 1ns/10ps

module ex_stage
  import ex_cfg_pkg::*;
  import ex_types_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  // Decode side
  input  ex_issue_t       issue_i,
  output logic            ex_ready_o,
  output logic            ex_valid_o,
  // Load unit data, one cycle after a load is accepted
  input  logic [XLEN-1:0] lsu_rdata_i,
  // WB back-pressure
  input  logic            wb_ready_i,
  // Register file ports
  output rf_write_t       fw_port_o,
  output rf_write_t       wb_port_o,
  // To fetch
  output logic            branch_decision_o,
  output logic [XLEN-1:0] jump_target_o
);

  logic [XLEN-1:0] alu_result;
  logic            alu_cmp;
  logic            contention;
  rf_write_t       alu_wr;
  rf_write_t       load_wr;
  // Entry 0 is the launch, last entry is the finished product
  mul_flight_t     mul_pipe [MUL_STAGES+1];

  ////////////////////////////////////////////////////////////////////////////
  // Issue and ALU
  ////////////////////////////////////////////////////////////////////////////

  ex_issue_ctrl i_issue_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_i           (issue_i),
    .alu_result_i      (alu_result),
    .alu_cmp_i         (alu_cmp),
    .wb_ready_i        (wb_ready_i),
    .contention_i      (contention),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o),
    .mul_o             (mul_pipe[0]),
    .alu_wr_o          (alu_wr),
    .load_wr_o         (load_wr),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o)
  );

  ex_alu i_alu (
    .op_i     (issue_i.alu_op),
    .op_a_i   (issue_i.op_a),
    .op_b_i   (issue_i.op_b),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Multiplier, one digit per stage
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < MUL_STAGES; k++) begin : g_mul_stage
    ex_mul_stage #(
      .STAGE_IDX (k)
    ) i_mul_stage (
      .clk      (clk),
      .rst_n    (rst_n),
      .flight_i (mul_pipe[k]),
      .flight_o (mul_pipe[k+1])
    );
  end

  // Writeback
  ex_wb_arbiter i_wb_arbiter (
    .mul_i        (mul_pipe[MUL_STAGES]),
    .alu_wr_i     (alu_wr),
    .load_wr_i    (load_wr),
    .lsu_rdata_i  (lsu_rdata_i),
    .fw_port_o    (fw_port_o),
    .wb_port_o    (wb_port_o),
    .contention_o (contention)
  );

endmodule

// ==== source/ex_types_pkg.sv ====
// Encodings match the execute stage only, decode must produce these exact opcode values
package ex_types_pkg;

  import ex_cfg_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////////////////////

  // Which unit handles the instruction
  typedef enum logic [2:0] {
    UNIT_NONE   = 3'd0,
    UNIT_ALU    = 3'd1,
    UNIT_BRANCH = 3'd2,
    UNIT_MUL    = 3'd3,
    UNIT_LOAD   = 3'd4
  } unit_e;

  // ALU operations, the last six are the branch comparisons
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Low-word multiply, MAC adds op_c
  typedef enum logic {
    MUL_MUL = 1'b0,
    MUL_MAC = 1'b1
  } mul_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////////////

  // One instruction from decode
  typedef struct packed {
    logic                  valid;
    unit_e                 unit;
    alu_op_e               alu_op;
    mul_op_e               mul_op;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    // MAC addend or branch target
    logic [XLEN-1:0]       op_c;
    logic [REG_ADDR_W-1:0] waddr;
    logic                  we;
  } ex_issue_t;

  // One product moving through the multiplier
  typedef struct packed {
    logic                  valid;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       op_a;
    // Digits of op_b not yet consumed, lowest digit is next
    logic [XLEN-1:0]       op_b;
    // Partial sum so far
    logic [XLEN-1:0]       acc;
  } mul_flight_t;

  // One register file write port
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } rf_write_t;

endpackage

// ==== source/ex_wb_arbiter.sv ====
// Multiplier results always win the forwarding port, and the load port is not back-pressured
`timescale 1ns/10ps

module ex_wb_arbiter
  import ex_cfg_pkg::*;
  import ex_types_pkg::*;
(
  input  mul_flight_t     mul_i,
  input  rf_write_t       alu_wr_i,
  input  rf_write_t       load_wr_i,
  input  logic [XLEN-1:0] lsu_rdata_i,
  output rf_write_t       fw_port_o,
  output rf_write_t       wb_port_o,
  output logic            contention_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////////////////////

  // Pipeline cannot stall, so a finished product always takes the port
  always_comb begin
    if (mul_i.valid) begin
      fw_port_o.we    = 1'b1;
      fw_port_o.waddr = mul_i.waddr;
      // acc holds the full low word after the last stage
      fw_port_o.wdata = mul_i.acc;
    end else begin
      fw_port_o = alu_wr_i;
    end
  end

  // ALU request meets a finished product
  // Issue side drops ready and retries next cycle
  assign contention_o = mul_i.valid & alu_wr_i.we;

  ////////////////////////////////////////////////////////////////////////////
  // Load writeback port
  ////////////////////////////////////////////////////////////////////////////

  // Address registered at accept, data arrives one cycle later
  always_comb begin
    wb_port_o.we    = load_wr_i.we;
    wb_port_o.waddr = load_wr_i.waddr;
    wb_port_o.wdata = lsu_rdata_i;
  end

endmodule

// ==== verification/ex_stage_assert.sv ====
// Checks handshake, reset state and multiply latency only, data values are left to the testbench
`timescale 1ns/10ps

module ex_stage_assert
  import ex_cfg_pkg::*;
  import ex_types_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input ex_issue_t issue_i,
  input logic      ex_ready_i,
  input logic      ex_valid_i,
  input rf_write_t fw_port_i,
  input rf_write_t wb_port_i
);

  logic mul_accept;

  // Multiply that actually launches, x0 targets are dropped at issue
  assign mul_accept = ex_valid_i & (issue_i.unit == UNIT_MUL) & issue_i.we &
                      (issue_i.waddr != '0);

  // Accept only with ready
  a_valid_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> ex_ready_i)
    else $error("ex_valid_o high while ex_ready_o low");

  // Both ports quiet in the first cycle out of reset
  a_quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !fw_port_i.we && !wb_port_i.we)
    else $error("register write seen in the first cycle after reset");

  // Fixed latency, the pipeline never stalls
  a_mul_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $past(mul_accept, MUL_STAGES) |->
      fw_port_i.we && (fw_port_i.waddr == $past(issue_i.waddr, MUL_STAGES)))
    else $error("multiply result missing on the forwarding port");

endmodule

bind ex_stage ex_stage_assert i_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .issue_i    (issue_i),
  .ex_ready_i (ex_ready_o),
  .ex_valid_i (ex_valid_o),
  .fw_port_i  (fw_port_o),
  .wb_port_i  (wb_port_o)
);

// ==== verification/ex_stage_tb.sv ====
// Directed tests where no multiply result is read by a later instruction while still in flight
`timescale 1ns/10ps

module ex_stage_tb
  import ex_cfg_pkg::*;
  import ex_types_pkg::*;
();

  // Under 100 cycles of traffic plus reset, so this trips only on a hang
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int NUM_REGS       = 2**REG_ADDR_W;

  logic            clk;
  logic            rst_n;
  ex_issue_t       issue_i;
  logic [XLEN-1:0] lsu_rdata_i;
  logic            wb_ready_i;
  logic            ex_ready_o;
  logic            ex_valid_o;
  rf_write_t       fw_port_o;
  rf_write_t       wb_port_o;
  logic            branch_decision_o;
  logic [XLEN-1:0] jump_target_o;

  // Outputs sampled in the middle of the low phase
  logic            smp_valid;
  logic            smp_ready;
  rf_write_t       smp_fw;
  rf_write_t       smp_wb;
  logic            smp_dec;
  logic [XLEN-1:0] smp_tgt;
  // Forwarding port history since the last instruction was presented
  rf_write_t       fw_hist[$];
  // Writes seen on the ports, and the values the reference model expects
  logic [XLEN-1:0] rf_seen [NUM_REGS];
  logic [XLEN-1:0] rf_expect [NUM_REGS];
  logic [31:0]     rng_state = 32'hb2;
  int              err_count = 0;
  int              tests_run = 0;
  int              tests_failed = 0;
  int              cycle_count = 0;

  ex_stage i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog
  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Error: run hit the %0d cycle limit, the DUT stopped responding", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic branch_expect(alu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    logic lt_u;
    logic lt_s;
    lt_u = (a < b);
    // Differing signs settle signed order by the sign bit alone
    lt_s = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : lt_u;
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return lt_s;
      ALU_GE:  return !lt_s;
      ALU_LTU: return lt_u;
      ALU_GEU: return !lt_u;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] alu_expect(alu_op_e op, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b);
    logic [SHAMT_W-1:0] sh;
    logic [XLEN-1:0]    fill;
    sh   = b[SHAMT_W-1:0];
    // Vacated top bits copy the sign for SRA
    fill = a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + XLEN'(1);
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return (a >> sh) | fill;
      ALU_SLT:  return XLEN'(branch_expect(ALU_LT, a, b));
      ALU_SLTU: return XLEN'(branch_expect(ALU_LTU, a, b));
      // Compare opcodes on the ALU path give the flag in bit 0
      default:  return XLEN'(branch_expect(op, a, b));
    endcase
  endfunction

  function automatic ex_issue_t make_issue(unit_e kind, alu_op_e aop, mul_op_e mop,
                                           logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                                           logic [XLEN-1:0] c, logic [REG_ADDR_W-1:0] rd,
                                           logic we);
    ex_issue_t ins;
    ins.valid  = 1'b1;
    ins.unit   = kind;
    ins.alu_op = aop;
    ins.mul_op = mop;
    ins.op_a   = a;
    ins.op_b   = b;
    ins.op_c   = c;
    ins.waddr  = rd;
    ins.we     = we;
    return ins;
  endfunction

  function automatic rf_write_t make_write(logic we, logic [REG_ADDR_W-1:0] waddr,
                                           logic [XLEN-1:0] wdata);
    rf_write_t wr;
    wr.we    = we;
    wr.waddr = waddr;
    wr.wdata = wdata;
    return wr;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Cycle stepping and compares
  ////////////////////////////////////////////////////////////////////////////

  // Entered at a falling edge with inputs already driven
  task automatic cycle();
    #2;
    smp_valid = ex_valid_o;
    smp_ready = ex_ready_o;
    smp_fw    = fw_port_o;
    smp_wb    = wb_port_o;
    smp_dec   = branch_decision_o;
    smp_tgt   = jump_target_o;
    fw_hist.push_back(fw_port_o);
    if (fw_port_o.we) rf_seen[fw_port_o.waddr] = fw_port_o.wdata;
    if (wb_port_o.we) rf_seen[wb_port_o.waddr] = wb_port_o.wdata;
    @(negedge clk);
  endtask

  // Holds the instruction until accepted and counts the refused cycles in held
  task automatic issue_and_wait(input ex_issue_t ins, output int held);
    held = 0;
    fw_hist.delete();
    issue_i = ins;
    cycle();
    while (!smp_valid) begin
      held++;
      cycle();
    end
    issue_i = '0;
  endtask

  // A port with we low carries no write, so its other fields are ignored
  task automatic check_write(string name, rf_write_t exp, rf_write_t act);
    if (exp.we !== act.we ||
        (exp.we && (exp.waddr !== act.waddr || exp.wdata !== act.wdata))) begin
      $display("MISMATCH %s expected we=%0b x%0d=%h actual we=%0b x%0d=%h", name,
               exp.we, exp.waddr, exp.wdata, act.we, act.waddr, act.wdata);
      err_count++;
    end
  endtask

  task automatic check_branch(string name, logic exp_dec, logic [XLEN-1:0] exp_tgt,
                              logic act_dec, logic [XLEN-1:0] act_tgt);
    if (exp_dec !== act_dec || exp_tgt !== act_tgt) begin
      $display("MISMATCH %s expected taken=%0b target=%h actual taken=%0b target=%h",
               name, exp_dec, exp_tgt, act_dec, act_tgt);
      err_count++;
    end
  endtask

  task automatic report_test(string name, int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("%-12s ok", name);
    end else begin
      tests_failed++;
      $display("%-12s %0d errors", name, err_count - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  // Every opcode on the ALU path, then a write aimed at x0
  task automatic test_alu();
    int                    errs;
    int                    held;
    alu_op_e               op;
    logic [XLEN-1:0]       a, b, res;
    logic [REG_ADDR_W-1:0] rd;
    errs = err_count;
    for (int k = 0; k < 16; k++) begin
      op  = alu_op_e'(k);
      a   = next_random();
      b   = next_random();
      rd  = REG_ADDR_W'(k + 1);
      res = alu_expect(op, a, b);
      issue_and_wait(make_issue(UNIT_ALU, op, MUL_MUL, a, b, '0, rd, 1'b1), held);
      check_write("alu_ops", make_write(1'b1, rd, res), smp_fw);
      rf_expect[rd] = res;
    end
    issue_and_wait(make_issue(UNIT_ALU, ALU_ADD, MUL_MUL, a, b, '0, '0, 1'b1), held);
    check_write("alu_x0", make_write(1'b0, '0, '0), smp_fw);
    report_test("alu_ops", errs);
  endtask

  // Branches go through while WB is stalled
  task automatic test_branch();
    int              errs;
    int              held;
    alu_op_e         op;
    logic [XLEN-1:0] a, b, c;
    errs       = err_count;
    wb_ready_i = 1'b0;
    for (int k = 10; k < 16; k++) begin
      for (int n = 0; n < 2; n++) begin
        op = alu_op_e'(k);
        a  = next_random();
        // First pass with equal operands
        b  = (n == 0) ? a : next_random();
        c  = next_random();
        issue_and_wait(make_issue(UNIT_BRANCH, op, MUL_MUL, a, b, c, '0, 1'b0), held);
        check_branch("branch", branch_expect(op, a, b), c, smp_dec, smp_tgt);
        if (held != 0) begin
          $display("Error: branch refused for %0d cycles while WB was stalled", held);
          err_count++;
        end
      end
    end
    wb_ready_i = 1'b1;
    report_test("branch", errs);
  endtask

  task automatic test_mul_single();
    int                    errs;
    int                    held;
    mul_op_e               mop;
    logic [XLEN-1:0]       a, b, c, res;
    logic [REG_ADDR_W-1:0] rd;
    errs = err_count;
    for (int n = 0; n < 2; n++) begin
      mop = mul_op_e'(n);
      a   = next_random();
      b   = next_random();
      c   = next_random();
      rd  = REG_ADDR_W'(17 + n);
      res = a * b;
      if (mop == MUL_MAC) res = res + c;
      issue_and_wait(make_issue(UNIT_MUL, ALU_ADD, mop, a, b, c, rd, 1'b1), held);
      // Result due exactly MUL_STAGES cycles after the accept
      repeat (MUL_STAGES) cycle();
      check_write("mul_single", make_write(1'b1, rd, res), smp_fw);
      rf_expect[rd] = res;
    end
    report_test("mul_single", errs);
  endtask

  // Four products back to back, then an ALU write that meets all of them
  task automatic test_pipeline();
    int              errs;
    int              held;
    logic [XLEN-1:0] a, b, c, res;
    logic [XLEN-1:0] exp_q[$];
    errs = err_count;
    for (int k = 0; k < 4; k++) begin
      a   = next_random();
      b   = next_random();
      c   = next_random();
      res = (k % 2 == 1) ? a * b + c : a * b;
      exp_q.push_back(res);
      rf_expect[19 + k] = res;
      issue_and_wait(make_issue(UNIT_MUL, ALU_ADD, mul_op_e'(k % 2), a, b, c,
                                REG_ADDR_W'(19 + k), 1'b1), held);
      if (held != 0) begin
        $display("Error: multiply %0d was refused while the pipeline had room", k);
        err_count++;
      end
    end
    a   = next_random();
    b   = next_random();
    res = alu_expect(ALU_SUB, a, b);
    issue_and_wait(make_issue(UNIT_ALU, ALU_SUB, MUL_MUL, a, b, '0, 5'd23, 1'b1), held);
    if (held != MUL_STAGES) begin
      $display("MISMATCH pipeline_hold expected %0d actual %0d", MUL_STAGES, held);
      err_count++;
    end
    // Products drain in issue order while the ALU write waits
    for (int k = 0; k < 4; k++) begin
      if (k < fw_hist.size()) begin
        check_write("pipeline_order", make_write(1'b1, REG_ADDR_W'(19 + k), exp_q[k]),
                    fw_hist[k]);
      end
    end
    check_write("pipeline_alu", make_write(1'b1, 5'd23, res), smp_fw);
    rf_expect[23] = res;
    report_test("pipeline", errs);
  endtask

  task automatic test_load();
    int              errs;
    int              held;
    logic [XLEN-1:0] data, b, c;
    errs = err_count;
    data = next_random();
    issue_and_wait(make_issue(UNIT_LOAD, ALU_ADD, MUL_MUL, next_random(), '0, '0,
                              5'd24, 1'b1), held);
    // Load unit answers in the cycle after the accept
    lsu_rdata_i = data;
    cycle();
    check_write("load_wb", make_write(1'b1, 5'd24, data), smp_wb);
    rf_expect[24] = data;
    lsu_rdata_i   = next_random();
    // The ALU instruction must wait under back-pressure
    b          = next_random();
    c          = next_random();
    wb_ready_i = 1'b0;
    issue_i    = make_issue(UNIT_ALU, ALU_XOR, MUL_MUL, b, c, '0, 5'd25, 1'b1);
    repeat (4) begin
      cycle();
      if (smp_valid || smp_ready) begin
        $display("Error: ALU instruction ready or accepted while wb_ready_i was low");
        err_count++;
      end
      check_write("load_clear", make_write(1'b0, '0, '0), smp_wb);
    end
    wb_ready_i = 1'b1;
    issue_and_wait(issue_i, held);
    check_write("stall_alu", make_write(1'b1, 5'd25, alu_expect(ALU_XOR, b, c)), smp_fw);
    rf_expect[25] = alu_expect(ALU_XOR, b, c);
    report_test("load", errs);
  endtask

  task automatic check_regfile();
    int errs;
    errs = err_count;
    for (int r = 0; r < NUM_REGS; r++) begin
      check_write("regfile", make_write(1'b1, REG_ADDR_W'(r), rf_expect[r]),
                  make_write(1'b1, REG_ADDR_W'(r), rf_seen[r]));
    end
    report_test("regfile", errs);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    issue_i     = '0;
    lsu_rdata_i = '0;
    wb_ready_i  = 1'b1;
    rst_n       = 1'b0;
    for (int r = 0; r < NUM_REGS; r++) begin
      rf_seen[r]   = '0;
      rf_expect[r] = '0;
    end
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    // First cycle out of reset stays idle so both ports show their reset state
    @(negedge clk);
    test_alu();
    test_branch();
    test_mul_single();
    test_pipeline();
    test_load();
    check_regfile();
    $display("%0d tests, %0d failing, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
